/* src/vic_pkg.sv */
package vic_pkg;

  typedef logic [3:0] color_idx_t; // one of the 16 palette colors

  // chip bus register map
  localparam logic [5:0] REG_CTRL       = 6'h11;
  localparam logic [5:0] REG_BORDER     = 6'h20;
  localparam logic [5:0] REG_BACKGROUND = 6'h21;
  localparam int         CTRL_DEN_BIT   = 4;     // DEN in control reg

  // 8-bit payload, read as a pixel or as a blank/sync word
  typedef union packed {
    struct packed {
      color_idx_t color;
      logic [3:0] spare;
    } pix;
    struct packed {
      logic       hsync;
      logic       vsync;
      logic [5:0] spare;
    } blank;
  } pix_payload_t;

  typedef struct packed {
    logic         is_pixel; // 1 = pixel view, 0 = blank view
    pix_payload_t payload;
  } pix_entry_t;

  // classic vic colors, 8-bit values shifted down to 6 bits
  function automatic logic [17:0] palette(input color_idx_t idx);
    case (idx)
      4'd0:  palette = {6'd0,  6'd0,  6'd0};  // black
      4'd1:  palette = {6'd63, 6'd63, 6'd63}; // white
      4'd2:  palette = {6'd26, 6'd13, 6'd10}; // red
      4'd3:  palette = {6'd28, 6'd41, 6'd44}; // cyan
      4'd4:  palette = {6'd27, 6'd15, 6'd33}; // purple
      4'd5:  palette = {6'd22, 6'd35, 6'd16}; // green
      4'd6:  palette = {6'd13, 6'd10, 6'd30}; // blue
      4'd7:  palette = {6'd46, 6'd49, 6'd27}; // yellow
      4'd8:  palette = {6'd27, 6'd19, 6'd9};  // orange
      4'd9:  palette = {6'd16, 6'd14, 6'd0};  // brown
      4'd10: palette = {6'd38, 6'd25, 6'd22}; // light red
      4'd11: palette = {6'd17, 6'd17, 6'd17}; // dark grey
      4'd12: palette = {6'd27, 6'd27, 6'd27}; // mid grey
      4'd13: palette = {6'd38, 6'd52, 6'd33}; // light green
      4'd14: palette = {6'd27, 6'd23, 6'd45}; // light blue
      4'd15: palette = {6'd37, 6'd37, 6'd37}; // light grey
    endcase
  endfunction

endpackage : vic_pkg

/* src/vic_regs.sv */
`timescale 1ns/1ps

module vic_regs (
  input  logic                clk_col4x_ntsc,
  input  logic                rst_n,
  input  logic                ce,               // chip enable, active low
  input  logic                rw,               // low = cpu write, high = cpu read
  input  logic [5:0]          adi,              // register select
  input  logic [7:0]          dbi,
  output logic [7:0]          dbo,
  output logic                vic_write_db,     // we own the data bus next cycle
  output vic_pkg::color_idx_t border_color,
  output vic_pkg::color_idx_t background_color,
  output logic                display_en
);
  import vic_pkg::*;

  logic [4:0] ctrl_reg; // only the low five bits exist
  logic       bus_wr;
  logic       bus_rd;
  logic [7:0] rd_mux;

  assign bus_wr = ~ce & ~rw;
  assign bus_rd = ~ce & rw;

  assign display_en = ctrl_reg[CTRL_DEN_BIT];

  // register writes land on the sampling edge
  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      ctrl_reg         <= '0;
      border_color     <= '0;
      background_color <= '0;
    end else if (bus_wr) begin
      case (adi)
        REG_CTRL:       ctrl_reg         <= dbi[4:0];
        REG_BORDER:     border_color     <= dbi[3:0];
        REG_BACKGROUND: background_color <= dbi[3:0];
        default: ;                               // unmapped, write ignored
      endcase
    end
  end

  // unused bits float high, as on the real chip
  always_comb begin
    case (adi)
      REG_CTRL:       rd_mux = {3'b111, ctrl_reg};
      REG_BORDER:     rd_mux = {4'hf, border_color};
      REG_BACKGROUND: rd_mux = {4'hf, background_color};
      default:        rd_mux = 8'hff;
    endcase
  end

  // read data and bus direction are registered together
  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      vic_write_db <= 1'b0;
    end else begin
      vic_write_db <= bus_rd; // stays up while ce low and rw high
    end
  end

  always_ff @(posedge clk_col4x_ntsc) begin
    if (bus_rd) dbo <= rd_mux; // held between reads
  end

endmodule : vic_regs

/* src/raster_gen.sv */
`timescale 1ns/1ps

module raster_gen #(
  parameter int H_ACTIVE = 16,
  parameter int H_TOTAL  = 24,
  parameter int H_SYNC   = 3,
  parameter int V_ACTIVE = 8,
  parameter int V_TOTAL  = 12,
  parameter int V_SYNC   = 2,
  parameter int BORDER   = 2
) (
  input  logic                clk_col4x_ntsc,
  input  logic                rst_n,
  input  vic_pkg::color_idx_t border_color,
  input  vic_pkg::color_idx_t background_color,
  input  logic                display_en,
  input  logic                full,             // fifo back-pressure
  output logic                wr_en,
  output vic_pkg::pix_entry_t wr_data
);
  import vic_pkg::*;

  localparam int CW = $clog2(H_TOTAL);
  localparam int LW = $clog2(V_TOTAL);

  logic [CW-1:0] col;
  logic [LW-1:0] line;
  logic          col_last;
  logic          line_last;
  logic          in_active;
  logic          in_inner;     // inside the border margin
  color_idx_t    border_s;     // frame shadows
  color_idx_t    background_s;
  logic          den_s;
  pix_entry_t    entry;

  assign wr_en     = ~full; // one entry per free slot
  assign wr_data   = entry;
  assign col_last  = (col == CW'(H_TOTAL - 1));
  assign line_last = (line == LW'(V_TOTAL - 1));

  // position walk, held while the fifo is full
  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      col  <= '0;
      line <= '0;
    end else if (wr_en) begin
      if (col_last) begin
        col  <= '0;
        line <= line_last ? '0 : line + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // register values only change at the frame boundary
  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      border_s     <= '0;
      background_s <= '0;
      den_s        <= 1'b0;
    end else if (wr_en && col_last && line_last) begin
      border_s     <= border_color;
      background_s <= background_color;
      den_s        <= display_en;
    end
  end

  assign in_active = (col < CW'(H_ACTIVE)) && (line < LW'(V_ACTIVE));
  assign in_inner  = (col >= CW'(BORDER)) && (col < CW'(H_ACTIVE - BORDER)) &&
                     (line >= LW'(BORDER)) && (line < LW'(V_ACTIVE - BORDER));

  always_comb begin
    entry = '0; // spare bits stay zero
    if (in_active) begin
      entry.is_pixel          = 1'b1;
      entry.payload.pix.color = (den_s && in_inner) ? background_s : border_s;
    end else begin
      entry.is_pixel            = 1'b0;
      entry.payload.blank.hsync = (col >= CW'(H_ACTIVE)) &&
                                  (col < CW'(H_ACTIVE + H_SYNC));
      entry.payload.blank.vsync = (line >= LW'(V_ACTIVE)) &&
                                  (line < LW'(V_ACTIVE + V_SYNC)); // whole line
    end
  end

endmodule : raster_gen

/* src/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk_col4x_ntsc,
  input  logic                rst_n,
  input  logic                wr_en,
  input  vic_pkg::pix_entry_t wr_data,
  input  logic                rd_en,
  output vic_pkg::pix_entry_t rd_data,  // head, valid while !empty
  output logic                full,
  output logic                empty
);
  import vic_pkg::*;

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  pix_entry_t  mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;       // 0..FIFO_DEPTH
  logic          do_wr;
  logic          do_rd;

  assign do_wr   = wr_en & ~full;
  assign do_rd   = rd_en & ~empty;
  assign full    = (count == (AW + 1)'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr]; // fall-through head

  always_ff @(posedge clk_col4x_ntsc) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

endmodule : pixel_fifo

/* src/rgb_out.sv */
`timescale 1ns/1ps

module rgb_out #(
  parameter int PIX_DIV = 2
) (
  input  logic                clk_col4x_ntsc,
  input  logic                rst_n,
  input  vic_pkg::pix_entry_t rd_data,
  input  logic                empty,
  output logic                rd_en,
  output logic [5:0]          red,
  output logic [5:0]          green,
  output logic [5:0]          blue,
  output logic                active,
  output logic                hsync,
  output logic                vsync,
  output logic                pix_strobe    // one cycle per new dot
);
  import vic_pkg::*;

  localparam int DW = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

  logic [DW-1:0] div_cnt;
  logic          tick;
  logic [17:0]   rgb;

  assign tick  = (div_cnt == DW'(PIX_DIV - 1));
  assign rd_en = tick & ~empty; // pop only when something is there
  assign rgb   = palette(rd_data.payload.pix.color);

  // free-running dot divider
  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      red        <= '0;
      green      <= '0;
      blue       <= '0;
      active     <= 1'b0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      pix_strobe <= 1'b0;
    end else begin
      pix_strobe <= rd_en;
      if (rd_en) begin
        if (rd_data.is_pixel) begin
          {red, green, blue} <= rgb;
          active <= 1'b1;
          hsync  <= 1'b0;
          vsync  <= 1'b0;
        end else begin
          {red, green, blue} <= '0; // blanked
          active <= 1'b0;
          hsync  <= rd_data.payload.blank.hsync;
          vsync  <= rd_data.payload.blank.vsync;
        end
      end
    end
  end

endmodule : rgb_out

/* src/vic_top.sv */
`timescale 1ns/1ps

module vic_top #(
  parameter int H_ACTIVE   = 16,
  parameter int H_TOTAL    = 24,
  parameter int H_SYNC     = 3,
  parameter int V_ACTIVE   = 8,
  parameter int V_TOTAL    = 12,
  parameter int V_SYNC     = 2,
  parameter int BORDER     = 2,
  parameter int FIFO_DEPTH = 8,
  parameter int PIX_DIV    = 2
) (
  input  logic       clk_col4x_ntsc,
  input  logic       rst_n,
  input  logic       ce,          // chip enable, active low
  input  logic       rw,          // low = write
  input  logic [5:0] adi,
  inout  tri   [7:0] dbl,         // shared cpu data bus
  output logic [5:0] red,
  output logic [5:0] green,
  output logic [5:0] blue,
  output logic       active,
  output logic       hsync,
  output logic       vsync,
  output logic       pix_strobe
);
  import vic_pkg::*;

  logic [7:0] dbo;
  logic       vic_write_db;
  color_idx_t border_color;
  color_idx_t background_color;
  logic       display_en;
  logic       wr_en;
  logic       rd_en;
  logic       full;
  logic       empty;
  pix_entry_t wr_data;
  pix_entry_t rd_data;

  vic_regs regs0 (
    .clk_col4x_ntsc, .rst_n, .ce, .rw, .adi,
    .dbi (dbl),
    .dbo, .vic_write_db, .border_color, .background_color, .display_en
  );

  raster_gen #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC),
    .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .BORDER(BORDER)
  ) gen0 (
    .clk_col4x_ntsc, .rst_n, .border_color, .background_color, .display_en,
    .full, .wr_en, .wr_data
  );

  pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
    .clk_col4x_ntsc, .rst_n, .wr_en, .wr_data, .rd_en, .rd_data, .full, .empty
  );

  rgb_out #(.PIX_DIV(PIX_DIV)) out0 (
    .clk_col4x_ntsc, .rst_n, .rd_data, .empty, .rd_en,
    .red, .green, .blue, .active, .hsync, .vsync, .pix_strobe
  );

  assign dbl = vic_write_db ? dbo : 8'bz; // drive only during a cpu read

endmodule : vic_top

/* verif/tb_vic_top.sv */
`timescale 1ns/1ps

module tb_vic_top;
  import vic_pkg::*;

  localparam int H_ACTIVE = 16;
  localparam int H_TOTAL  = 24;
  localparam int H_SYNC   = 3;
  localparam int V_ACTIVE = 8;
  localparam int V_TOTAL  = 12;
  localparam int V_SYNC   = 2;
  localparam int BORDER   = 2;
  localparam int PIX_DIV  = 2;
  localparam int SEED     = 11713;
  // six frames of dots at 4 ns per clock, plus slack for reset and startup
  localparam int WATCHDOG_NS = 6 * H_TOTAL * V_TOTAL * PIX_DIV * 4 + 1000;

  // classic 8-bit vic colors, top six bits of each channel reach the pins
  localparam logic [23:0] VIC_COLORS [16] = '{
    24'h000000, 24'hffffff, 24'h68372b, 24'h70a4b2,
    24'h6f3d86, 24'h588d43, 24'h352879, 24'hb8c76f,
    24'h6f4f25, 24'h433900, 24'h9a6759, 24'h444444,
    24'h6c6c6c, 24'h9ad284, 24'h6c5eb5, 24'h959595
  };

  logic       clk_col4x_ntsc;
  logic       rst_n;
  logic       ce;
  logic       rw;
  logic [5:0] adi;
  logic [7:0] db_drv;     // cpu side of the data bus
  logic       db_oe;
  wire  [7:0] dbl;
  logic [5:0] red;
  logic [5:0] green;
  logic [5:0] blue;
  logic       active;
  logic       hsync;
  logic       vsync;
  logic       pix_strobe;
  logic       strobe_seen;
  int         gap;        // cycles since the last strobe

  // reference raster position of the next strobe, counted from reset
  int         col;
  int         line;
  int         frame_cnt;
  color_idx_t cur_border;  // colors the current output frame was built with
  color_idx_t cur_bg;
  logic       cur_den;
  color_idx_t pend_border; // last values written, picked up at the next frame
  color_idx_t pend_bg;
  logic       pend_den;

  assign dbl = db_oe ? db_drv : 8'bz;

  vic_top #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC),
    .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .BORDER(BORDER),
    .FIFO_DEPTH(8), .PIX_DIV(PIX_DIV)
  ) dut0 (
    .clk_col4x_ntsc, .rst_n, .ce, .rw, .adi, .dbl,
    .red, .green, .blue, .active, .hsync, .vsync, .pix_strobe
  );

  initial begin
    clk_col4x_ntsc = 1'b0;
    forever #2 clk_col4x_ntsc = ~clk_col4x_ntsc;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    stop_run($sformatf("error at %0t ns: %s expected 0x%0h, got 0x%0h",
                       $time, sig, exp, got));
  endtask

  function automatic logic [17:0] rgb6_of(input color_idx_t idx);
    logic [23:0] c;
    c = VIC_COLORS[idx];
    return {c[23:18], c[15:10], c[7:2]};
  endfunction

  task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
    @(posedge clk_col4x_ntsc);
    ce     <= 1'b0;
    rw     <= 1'b0;
    adi    <= addr;
    db_drv <= data;
    db_oe  <= 1'b1;
    @(posedge clk_col4x_ntsc); // register takes the value here
    ce    <= 1'b1;
    rw    <= 1'b1;
    db_oe <= 1'b0;
  endtask

  task automatic check_readback(input logic [5:0] addr, input logic [7:0] exp);
    logic [7:0] got;
    @(posedge clk_col4x_ntsc);
    ce  <= 1'b0;
    rw  <= 1'b1;
    adi <= addr;
    @(posedge clk_col4x_ntsc); // dbo loaded, chip turns the bus around
    ce <= 1'b1;
    @(posedge clk_col4x_ntsc);
    got = dbl; // still driven by the chip up to this edge
    assert (got == exp) else report_mismatch("dbl", 32'(exp), 32'(got));
  endtask

  task automatic readback_test();
    logic [7:0] v;
    repeat (4) begin
      v = 8'($urandom);
      bus_write(REG_BORDER, v);
      check_readback(REG_BORDER, {4'hf, v[3:0]});
      v = 8'($urandom);
      bus_write(REG_BACKGROUND, v);
      check_readback(REG_BACKGROUND, {4'hf, v[3:0]});
      v = 8'($urandom);
      bus_write(REG_CTRL, v);
      check_readback(REG_CTRL, {3'b111, v[4:0]});
    end
    check_readback(6'h00, 8'hff); // unmapped
    check_readback(6'h12, 8'hff);
    check_readback(6'h3f, 8'hff);
  endtask

  task automatic set_colors(input logic den);
    color_idx_t br;
    color_idx_t bg;
    br = 4'($urandom);
    bg = 4'($urandom);
    if (bg == br) bg = br + 4'd1; // keep the inner area distinguishable
    bus_write(REG_BORDER, {4'h0, br});
    bus_write(REG_BACKGROUND, {4'h0, bg});
    bus_write(REG_CTRL, 8'(den) << CTRL_DEN_BIT);
    pend_border = br;
    pend_bg     = bg;
    pend_den    = den;
  endtask

  // output is a few dots into the first active line of frame n
  task automatic wait_first_line(input int n);
    wait (frame_cnt == n && line == 0 && col == 4);
  endtask

  always @(posedge clk_col4x_ntsc) begin
    if (!rst_n) begin
      strobe_seen <= 1'b0;
      gap         <= 0;
    end else if (pix_strobe) begin
      strobe_seen <= 1'b1;
      gap         <= 1;
    end else begin
      gap <= gap + 1;
    end
  end

  // bus direction flag follows a sampled read by exactly one cycle
  assert property (@(posedge clk_col4x_ntsc) disable iff (!rst_n)
    dut0.vic_write_db == $past(!ce && rw))
    else report_mismatch("vic_write_db", 32'(!$sampled(dut0.vic_write_db)),
                         32'($sampled(dut0.vic_write_db)));

  // after the first dot, one strobe every PIX_DIV cycles and none between
  assert property (@(posedge clk_col4x_ntsc) disable iff (!rst_n)
    strobe_seen |-> pix_strobe == (gap == PIX_DIV))
    else report_mismatch("pix_strobe", 32'($sampled(gap) == PIX_DIV),
                         32'($sampled(pix_strobe)));

  always @(posedge clk_col4x_ntsc) begin
    logic        exp_act;
    logic        exp_hs;
    logic        exp_vs;
    logic        inner;
    logic [17:0] exp_rgb;
    if (!rst_n) begin
      col        = 0;
      line       = 0;
      frame_cnt  = 0;
      cur_border = '0;
      cur_bg     = '0;
      cur_den    = 1'b0;
    end else if (pix_strobe) begin
      if (col == 0 && line == 0) begin
        cur_border = pend_border; // new frame, latched register values
        cur_bg     = pend_bg;
        cur_den    = pend_den;
      end
      exp_act = (col < H_ACTIVE) && (line < V_ACTIVE);
      exp_hs  = !exp_act && (col >= H_ACTIVE) && (col < H_ACTIVE + H_SYNC);
      exp_vs  = !exp_act && (line >= V_ACTIVE) && (line < V_ACTIVE + V_SYNC);
      inner   = (col >= BORDER) && (col < H_ACTIVE - BORDER) &&
                (line >= BORDER) && (line < V_ACTIVE - BORDER);
      exp_rgb = '0; // blanked outside the active area
      if (exp_act) exp_rgb = rgb6_of((cur_den && inner) ? cur_bg : cur_border);
      assert (active == exp_act) else report_mismatch("active", 32'(exp_act), 32'(active));
      assert (hsync == exp_hs) else report_mismatch("hsync", 32'(exp_hs), 32'(hsync));
      assert (vsync == exp_vs) else report_mismatch("vsync", 32'(exp_vs), 32'(vsync));
      assert ({red, green, blue} == exp_rgb)
        else report_mismatch("rgb", 32'(exp_rgb), 32'({red, green, blue}));
      col = col + 1;
      if (col == H_TOTAL) begin
        col  = 0;
        line = line + 1;
        if (line == V_TOTAL) begin
          line      = 0;
          frame_cnt = frame_cnt + 1;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    stop_run("timeout, the frames did not complete in time");
  end

  initial begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    ce          = 1'b1;
    rw          = 1'b1;
    adi         = '0;
    db_drv      = '0;
    db_oe       = 1'b0;
    pend_border = '0;
    pend_bg     = '0;
    pend_den    = 1'b0;
    repeat (8) @(posedge clk_col4x_ntsc);
    assert ({active, hsync, vsync, pix_strobe} == 4'b0)
      else report_mismatch("active/hsync/vsync/pix_strobe", 0,
                           32'({active, hsync, vsync, pix_strobe}));
    assert ({red, green, blue} == '0) else report_mismatch("rgb", 0, 32'({red, green, blue}));
    assert (!dut0.vic_write_db) else report_mismatch("vic_write_db", 0, 1);
    rst_n <= 1'b1;
    readback_test();
    set_colors(1'b1);           // shows in frame 1
    wait_first_line(1);
    set_colors(1'b1);
    wait_first_line(2);
    set_colors(1'b0);           // frame 3 is all border
    wait_first_line(3);
    set_colors(1'b1);
    wait (frame_cnt == 5);
    $display("Everything OK");
    $finish;
  end

endmodule : tb_vic_top

/* verilog.f */
src/vic_pkg.sv
src/vic_regs.sv
src/raster_gen.sv
src/pixel_fifo.sv
src/rgb_out.sv
src/vic_top.sv
verif/tb_vic_top.sv

/* Makefile */
# Verilator flow for the VIC display core

.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_vic_top | tee sim.log
	grep -q "Everything OK" sim.log

build:
	verilator --binary --timing --assert --top-module tb_vic_top -f verilog.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_vic_top -f verilog.f

clean:
	rm -rf obj_dir sim.log
